// ==== hdl/mem_sys_pkg.sv ====
package mem_sys_pkg;

   ////////////////////
   // Widths
   ////////////////////

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;

   // Byte address, low two bits unused for aligned words
   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] word_t;

   ////////////////////
   // Encodings
   ////////////////////

   // Processor request type
   typedef enum logic [0:0] {
      OP_READ  = 1'b0,
      OP_WRITE = 1'b1
   } cpu_op_e;

   // Memory controller FSM
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_WRITEBACK,
      ST_FILL,
      ST_INSTALL,
      ST_PERIPH,
      ST_PERIPH_DONE
   } mc_state_e;

endpackage

// ==== hdl/mem_controller.sv ====
`timescale 1ns/1ns

module mem_controller import mem_sys_pkg::*; #(
   parameter addr_t PERIPH_BASE = 32'h8000_0000
) (
   input  logic      Clk,
   input  logic      rst_n_i,
   input  logic      cpu_en_i,
   input  cpu_op_e   cpu_op_i,
   input  addr_t     cpu_addr_i,
   input  word_t     periph_rdata_i,
   input  logic      periph_done_i,
   input  logic      hit_i,
   input  logic      victim_dirty_i,
   input  logic      lf_done_i,
   input  logic      lw_done_i,
   output logic      cpu_stall_o,
   output word_t     periph_sel_rdata_o,
   output logic      rdata_from_periph_o,
   output logic      periph_rd_o,
   output logic      periph_wr_o,
   output addr_t     periph_addr_o,
   output logic      lf_start_o,
   output logic      lw_start_o,
   output logic      cache_write_o,
   output logic      cache_install_o
);

   mc_state_e state_q;
   mc_state_e state_d;
   logic      is_periph;
   logic      req_cached;
   logic      req_miss;
   logic      fill_kick_q;
   logic      periph_rd_q;
   logic      periph_wr_q;
   word_t     periph_rdata_q;

   // Uncached region starts at PERIPH_BASE
   assign is_periph  = (cpu_addr_i >= PERIPH_BASE);
   assign req_cached = cpu_en_i && !is_periph;
   assign req_miss   = req_cached && !hit_i;

   ////////////////////
   // Next state
   ////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (cpu_en_i && is_periph) begin
               state_d = ST_PERIPH;
            end else if (req_miss) begin
               // Dirty victim must leave before the new line comes in
               state_d = victim_dirty_i ? ST_WRITEBACK : ST_FILL;
            end
         end
         ST_WRITEBACK: begin
            if (lw_done_i) begin
               state_d = ST_FILL;
            end
         end
         ST_FILL: begin
            if (lf_done_i) begin
               state_d = ST_INSTALL;
            end
         end
         ST_PERIPH: begin
            if (periph_done_i) begin
               state_d = ST_PERIPH_DONE;
            end
         end
         // Install and peripheral completion last one cycle
         default: state_d = ST_IDLE;
      endcase
   end

   ////////////////////
   // Outputs
   ////////////////////

   assign cpu_stall_o = cpu_en_i && (state_q != ST_PERIPH_DONE) &&
                        !((state_q == ST_IDLE) && req_cached && hit_i);

   assign lw_start_o      = (state_q == ST_IDLE) && req_miss && victim_dirty_i;
   assign lf_start_o      = ((state_q == ST_IDLE) && req_miss && !victim_dirty_i) ||
                            fill_kick_q;
   assign cache_write_o   = (state_q == ST_IDLE) && req_cached && hit_i &&
                            (cpu_op_i == OP_WRITE);
   assign cache_install_o = (state_q == ST_INSTALL);

   assign rdata_from_periph_o = (state_q == ST_PERIPH_DONE);
   assign periph_sel_rdata_o  = periph_rdata_q;
   assign periph_rd_o         = periph_rd_q;
   assign periph_wr_o         = periph_wr_q;
   assign periph_addr_o       = cpu_addr_i;

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         state_q     <= ST_IDLE;
         fill_kick_q <= 1'b0;
         periph_rd_q <= 1'b0;
         periph_wr_q <= 1'b0;
      end else begin
         state_q     <= state_d;
         // Fill starts the cycle after the writeback finishes
         fill_kick_q <= (state_q == ST_WRITEBACK) && lw_done_i;
         periph_rd_q <= (state_q == ST_IDLE) && cpu_en_i && is_periph &&
                        (cpu_op_i == OP_READ);
         periph_wr_q <= (state_q == ST_IDLE) && cpu_en_i && is_periph &&
                        (cpu_op_i == OP_WRITE);
      end
   end

   // Peripheral read word, held for the completing cycle
   always_ff @(posedge Clk) begin
      if ((state_q == ST_PERIPH) && periph_done_i) begin
         periph_rdata_q <= periph_rdata_i;
      end
   end

endmodule

// ==== hdl/data_cache.sv ====
`timescale 1ns/1ns

module data_cache import mem_sys_pkg::*; #(
   parameter int unsigned NUM_LINES  = 8,
   parameter int unsigned LINE_WORDS = 4
) (
   input  logic                         Clk,
   input  logic                         rst_n_i,
   input  addr_t                        addr_i,
   input  word_t                        wdata_i,
   input  logic                         write_i,
   input  logic                         install_i,
   input  logic [LINE_WORDS*DATA_W-1:0] fill_line_i,
   output word_t                        rdata_o,
   output logic                         hit_o,
   output logic                         victim_dirty_o,
   output addr_t                        victim_addr_o,
   output logic [LINE_WORDS*DATA_W-1:0] victim_line_o
);

   localparam int OFF_W = $clog2(LINE_WORDS);
   localparam int IDX_W = $clog2(NUM_LINES);
   localparam int TAG_W = ADDR_W - IDX_W - OFF_W - 2;

   logic [TAG_W-1:0]     tag_q  [NUM_LINES];
   word_t                data_q [NUM_LINES][LINE_WORDS];
   logic [NUM_LINES-1:0] valid_q;
   logic [NUM_LINES-1:0] dirty_q;

   logic [OFF_W-1:0] off;
   logic [IDX_W-1:0] idx;
   logic [TAG_W-1:0] tag;

   // Address split: tag | index | word offset | byte
   assign off = addr_i[OFF_W+1:2];
   assign idx = addr_i[IDX_W+OFF_W+1:OFF_W+2];
   assign tag = addr_i[ADDR_W-1:IDX_W+OFF_W+2];

   assign hit_o          = valid_q[idx] && (tag_q[idx] == tag);
   assign victim_dirty_o = valid_q[idx] && dirty_q[idx];
   assign victim_addr_o  = {tag_q[idx], idx, {(OFF_W + 2){1'b0}}};
   assign rdata_o        = data_q[idx][off];

   // Whole resident line at this index, word 0 in the low bits
   always_comb begin
      for (int k = 0; k < LINE_WORDS; k++) begin
         victim_line_o[k*DATA_W +: DATA_W] = data_q[idx][k];
      end
   end

   ////////////////////
   // Line state
   ////////////////////

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (install_i) begin
         valid_q[idx] <= 1'b1;
         dirty_q[idx] <= 1'b0;
      end else if (write_i) begin
         dirty_q[idx] <= 1'b1;
      end
   end

   // Tag and data arrays
   always_ff @(posedge Clk) begin
      if (install_i) begin
         tag_q[idx] <= tag;
         for (int k = 0; k < LINE_WORDS; k++) begin
            data_q[idx][k] <= fill_line_i[k*DATA_W +: DATA_W];
         end
      end else if (write_i) begin
         data_q[idx][off] <= wdata_i;
      end
   end

endmodule

// ==== hdl/linefill_buffer.sv ====
`timescale 1ns/1ns

module linefill_buffer import mem_sys_pkg::*; #(
   parameter int unsigned LINE_WORDS = 4
) (
   input  logic                         Clk,
   input  logic                         rst_n_i,
   input  logic                         start_i,
   input  addr_t                        addr_i,
   input  word_t                        mem_rdata_i,
   input  logic                         mem_rvalid_i,
   output logic                         mem_rd_o,
   output addr_t                        mem_raddr_o,
   output logic [LINE_WORDS*DATA_W-1:0] line_o,
   output logic                         done_o
);

   localparam int OFF_W = $clog2(LINE_WORDS);

   logic                         busy_q;
   logic [OFF_W-1:0]             cnt_q;
   logic                         rd_q;
   logic                         done_q;
   addr_t                        base_q;
   logic [LINE_WORDS*DATA_W-1:0] line_q;

   assign mem_rd_o    = rd_q;
   assign mem_raddr_o = base_q;
   assign line_o      = line_q;
   assign done_o      = done_q;

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         rd_q   <= 1'b0;
         done_q <= 1'b0;
      end else begin
         rd_q   <= start_i;
         done_q <= 1'b0;
         if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (busy_q && mem_rvalid_i) begin
            cnt_q <= cnt_q + 1'b1;
            // Last word of the burst
            if (cnt_q == OFF_W'(LINE_WORDS - 1)) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge Clk) begin
      if (start_i) begin
         base_q <= {addr_i[ADDR_W-1:OFF_W+2], {(OFF_W + 2){1'b0}}};
      end
      if (busy_q && mem_rvalid_i) begin
         line_q[cnt_q*DATA_W +: DATA_W] <= mem_rdata_i;
      end
   end

endmodule

// ==== hdl/line_write_buffer.sv ====
`timescale 1ns/1ns

module line_write_buffer import mem_sys_pkg::*; #(
   parameter int unsigned LINE_WORDS = 4
) (
   input  logic                         Clk,
   input  logic                         rst_n_i,
   input  logic                         start_i,
   input  logic [LINE_WORDS*DATA_W-1:0] line_i,
   input  addr_t                        addr_i,
   output logic                         mem_wr_o,
   output addr_t                        mem_waddr_o,
   output word_t                        mem_wdata_o,
   output logic                         done_o,
   input  logic                         mem_wack_i
);

   localparam int OFF_W = $clog2(LINE_WORDS);

   logic                         busy_q;
   logic [OFF_W-1:0]             cnt_q;
   logic                         done_q;
   addr_t                        base_q;
   logic [LINE_WORDS*DATA_W-1:0] line_q;

   // Current word stays on the port until acknowledged
   assign mem_wr_o    = busy_q;
   assign mem_waddr_o = base_q + (addr_t'(cnt_q) << 2);
   assign mem_wdata_o = line_q[cnt_q*DATA_W +: DATA_W];
   assign done_o      = done_q;

   ////////////////////
   // Word sequencing
   ////////////////////

   always_ff @(posedge Clk) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         cnt_q  <= '0;
         done_q <= 1'b0;
      end else begin
         done_q <= 1'b0;
         if (start_i) begin
            busy_q <= 1'b1;
            cnt_q  <= '0;
         end else if (busy_q && mem_wack_i) begin
            if (cnt_q == OFF_W'(LINE_WORDS - 1)) begin
               busy_q <= 1'b0;
               done_q <= 1'b1;
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   // Private copy of the victim, so the cache line is free for the refill
   always_ff @(posedge Clk) begin
      if (start_i) begin
         line_q <= line_i;
         base_q <= addr_i;
      end
   end

endmodule

// ==== hdl/mem_subsystem.sv ====
`timescale 1ns/1ns

module mem_subsystem import mem_sys_pkg::*; #(
   parameter int unsigned NUM_LINES   = 8,
   parameter int unsigned LINE_WORDS  = 4,
   parameter addr_t       PERIPH_BASE = 32'h8000_0000
) (
   input  logic    Clk,
   input  logic    rst_n_i,
   // Processor
   input  logic    cpu_en_i,
   input  cpu_op_e cpu_op_i,
   input  addr_t   cpu_addr_i,
   input  word_t   cpu_wdata_i,
   output word_t   cpu_rdata_o,
   output logic    cpu_stall_o,
   // Memory
   output logic    mem_rd_o,
   output addr_t   mem_raddr_o,
   input  word_t   mem_rdata_i,
   input  logic    mem_rvalid_i,
   output logic    mem_wr_o,
   output addr_t   mem_waddr_o,
   output word_t   mem_wdata_o,
   input  logic    mem_wack_i,
   // Peripheral
   output logic    periph_rd_o,
   output logic    periph_wr_o,
   output addr_t   periph_addr_o,
   output word_t   periph_wdata_o,
   input  word_t   periph_rdata_i,
   input  logic    periph_done_i
);

   logic                         hit;
   logic                         victim_dirty;
   logic                         lf_start;
   logic                         lf_done;
   logic                         lw_start;
   logic                         lw_done;
   logic                         cache_write;
   logic                         cache_install;
   logic                         rdata_from_periph;
   word_t                        cache_rdata;
   word_t                        periph_sel_rdata;
   addr_t                        victim_addr;
   logic [LINE_WORDS*DATA_W-1:0] victim_line;
   logic [LINE_WORDS*DATA_W-1:0] fill_line;

   assign cpu_rdata_o    = rdata_from_periph ? periph_sel_rdata : cache_rdata;
   assign periph_wdata_o = cpu_wdata_i;

   mem_controller #(
      .PERIPH_BASE (PERIPH_BASE)
   ) i_mem_controller (
      .Clk                 (Clk),
      .rst_n_i             (rst_n_i),
      .cpu_en_i            (cpu_en_i),
      .cpu_op_i            (cpu_op_i),
      .cpu_addr_i          (cpu_addr_i),
      .periph_rdata_i      (periph_rdata_i),
      .periph_done_i       (periph_done_i),
      .hit_i               (hit),
      .victim_dirty_i      (victim_dirty),
      .lf_done_i           (lf_done),
      .lw_done_i           (lw_done),
      .cpu_stall_o         (cpu_stall_o),
      .periph_sel_rdata_o  (periph_sel_rdata),
      .rdata_from_periph_o (rdata_from_periph),
      .periph_rd_o         (periph_rd_o),
      .periph_wr_o         (periph_wr_o),
      .periph_addr_o       (periph_addr_o),
      .lf_start_o          (lf_start),
      .lw_start_o          (lw_start),
      .cache_write_o       (cache_write),
      .cache_install_o     (cache_install)
   );

   data_cache #(
      .NUM_LINES  (NUM_LINES),
      .LINE_WORDS (LINE_WORDS)
   ) i_data_cache (
      .Clk            (Clk),
      .rst_n_i        (rst_n_i),
      .addr_i         (cpu_addr_i),
      .wdata_i        (cpu_wdata_i),
      .write_i        (cache_write),
      .install_i      (cache_install),
      .fill_line_i    (fill_line),
      .rdata_o        (cache_rdata),
      .hit_o          (hit),
      .victim_dirty_o (victim_dirty),
      .victim_addr_o  (victim_addr),
      .victim_line_o  (victim_line)
   );

   linefill_buffer #(
      .LINE_WORDS (LINE_WORDS)
   ) i_linefill_buffer (
      .Clk          (Clk),
      .rst_n_i      (rst_n_i),
      .start_i      (lf_start),
      .addr_i       (cpu_addr_i),
      .mem_rdata_i  (mem_rdata_i),
      .mem_rvalid_i (mem_rvalid_i),
      .mem_rd_o     (mem_rd_o),
      .mem_raddr_o  (mem_raddr_o),
      .line_o       (fill_line),
      .done_o       (lf_done)
   );

   line_write_buffer #(
      .LINE_WORDS (LINE_WORDS)
   ) i_line_write_buffer (
      .Clk         (Clk),
      .rst_n_i     (rst_n_i),
      .start_i     (lw_start),
      .line_i      (victim_line),
      .addr_i      (victim_addr),
      .mem_wr_o    (mem_wr_o),
      .mem_waddr_o (mem_waddr_o),
      .mem_wdata_o (mem_wdata_o),
      .done_o      (lw_done),
      .mem_wack_i  (mem_wack_i)
   );

endmodule

// ==== bench/tb_mem_subsystem.sv ====
`timescale 1ns/1ns

module tb_mem_subsystem import mem_sys_pkg::*; ();

   localparam int    CLK_PERIOD        = 40;
   localparam int    LINE_WORDS        = 4;
   localparam int    CYCLES_PER_VECTOR = 40;
   localparam string VEC_FILE          = "bench/mem_vectors.txt";

   logic    Clk;
   logic    rst_n_i;
   logic    cpu_en_i;
   cpu_op_e cpu_op_i;
   addr_t   cpu_addr_i;
   word_t   cpu_wdata_i;
   word_t   cpu_rdata_o;
   logic    cpu_stall_o;
   logic    mem_rd_o;
   addr_t   mem_raddr_o;
   word_t   mem_rdata_i    = '0;
   logic    mem_rvalid_i   = 1'b0;
   logic    mem_wr_o;
   addr_t   mem_waddr_o;
   word_t   mem_wdata_o;
   logic    mem_wack_i     = 1'b0;
   logic    periph_rd_o;
   logic    periph_wr_o;
   addr_t   periph_addr_o;
   word_t   periph_wdata_o;
   word_t   periph_rdata_i = '0;
   logic    periph_done_i  = 1'b0;

   // Vector table
   string   vec_name [$];
   cpu_op_e vec_op   [$];
   addr_t   vec_addr [$];
   word_t   vec_wdata[$];
   word_t   vec_rdata[$];
   int      vec_nrd  [$];
   int      vec_nwr  [$];
   int      vec_nper [$];

   // Model state
   word_t mem_model  [addr_t];
   word_t shadow     [addr_t];
   word_t periph_log [addr_t];
   word_t rng_state      = 32'd21790;
   string cur_name       = "reset";
   int    timeout_cycles = 0;
   int    rd_pulses      = 0;
   int    wr_words       = 0;
   int    per_strobes    = 0;
   int    rd_left        = 0;
   int    rd_gap         = 0;
   int    wr_gap         = 0;
   int    per_wait       = 0;
   addr_t rd_addr;
   addr_t per_addr;

   mem_subsystem i_mem_subsystem (.*);

   initial begin
      Clk = 1'b0;
      forever #(CLK_PERIOD / 2) Clk = ~Clk;
   end

   ////////////////////
   // Helpers
   ////////////////////

   function automatic word_t next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   // Power-up content of external memory
   function automatic word_t rule_word(addr_t a);
      return {a[ADDR_W-1:2], 2'b00} ^ 32'hA5A5_0000;
   endfunction

   // What memory should hold once every processor write has landed
   function automatic word_t expected_mem_word(addr_t a);
      return shadow.exists(a) ? shadow[a] : rule_word(a);
   endfunction

   task automatic report_error();
      $display("Done: errors found");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_count(string what, int expected, int actual);
      assert (actual == expected) else begin
         $display("MISMATCH %s %s: expected %0d, actual %0d",
                  cur_name, what, expected, actual);
         report_error();
      end
   endtask

   task automatic load_vectors();
      int    fd;
      int    cnt;
      string line;
      string name;
      string op_s;
      addr_t a;
      word_t wd;
      word_t rd;
      int    nr;
      int    nw;
      int    np;
      fd = $fopen(VEC_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open vector file %s", VEC_FILE);
         report_error();
      end
      while (!$feof(fd)) begin
         if ($fgets(line, fd) != 0) begin
            cnt = $sscanf(line, "%s %s %h %h %h %d %d %d", name, op_s, a, wd, rd, nr, nw, np);
            // Comment and blank lines do not parse fully
            if (cnt == 8) begin
               vec_name.push_back(name);
               vec_op.push_back((op_s == "W") ? OP_WRITE : OP_READ);
               vec_addr.push_back(a);
               vec_wdata.push_back(wd);
               vec_rdata.push_back(rd);
               vec_nrd.push_back(nr);
               vec_nwr.push_back(nw);
               vec_nper.push_back(np);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic run_vector(int n);
      int    rd_start;
      int    wr_start;
      int    per_start;
      int    stalls;
      word_t got;
      cur_name  = vec_name[n];
      rd_start  = rd_pulses;
      wr_start  = wr_words;
      per_start = per_strobes;
      stalls    = 0;
      cpu_en_i    <= 1'b1;
      cpu_op_i    <= vec_op[n];
      cpu_addr_i  <= vec_addr[n];
      cpu_wdata_i <= vec_wdata[n];
      @(negedge Clk);
      while (cpu_stall_o) begin
         stalls++;
         @(negedge Clk);
      end
      got = cpu_rdata_o;
      if (vec_op[n] == OP_READ) begin
         assert (got == vec_rdata[n]) else begin
            $display("MISMATCH %s read data: expected %h, actual %h",
                     cur_name, vec_rdata[n], got);
            report_error();
         end
      end
      check_count("line reads", vec_nrd[n], rd_pulses - rd_start);
      check_count("written words", vec_nwr[n], wr_words - wr_start);
      check_count("peripheral strobes", vec_nper[n], per_strobes - per_start);
      // Hits complete in the cycle they are presented
      if ((vec_nrd[n] == 0) && (vec_nwr[n] == 0) && (vec_nper[n] == 0)) begin
         check_count("stall cycles", 0, stalls);
      end
      if ((vec_op[n] == OP_WRITE) && (vec_nper[n] == 0)) begin
         shadow[vec_addr[n]] = vec_wdata[n];
      end else if (vec_op[n] == OP_WRITE) begin
         assert (periph_log.exists(vec_addr[n]) && periph_log[vec_addr[n]] == vec_wdata[n])
         else begin
            $display("Peripheral write to %h by %s was not recorded with data %h",
                     vec_addr[n], cur_name, vec_wdata[n]);
            report_error();
         end
      end
      // Completing edge
      @(posedge Clk);
   endtask

   ////////////////////
   // Memory model
   ////////////////////

   // Line reads, one word per mem_rvalid_i with random gaps
   always @(posedge Clk) begin
      mem_rvalid_i <= 1'b0;
      if (mem_rd_o) begin
         rd_pulses++;
         rd_left = LINE_WORDS;
         rd_addr = mem_raddr_o;
         rd_gap  = next_random() % 4;
      end else if (rd_left > 0) begin
         if (rd_gap == 0) begin
            mem_rdata_i  <= mem_model.exists(rd_addr) ? mem_model[rd_addr] : rule_word(rd_addr);
            mem_rvalid_i <= 1'b1;
            rd_addr = rd_addr + 4;
            rd_left--;
            rd_gap = next_random() % 4;
         end else begin
            rd_gap--;
         end
      end
   end

   // Line writes, checked word by word before the ack
   always @(posedge Clk) begin
      mem_wack_i <= 1'b0;
      if (mem_wr_o && !mem_wack_i) begin
         if (wr_gap == 0) begin
            assert (((mem_waddr_o >> 2) % LINE_WORDS) == (wr_words % LINE_WORDS)) else begin
               $display("MISMATCH %s writeback order: expected word %0d, actual word %0d",
                        cur_name, wr_words % LINE_WORDS, (mem_waddr_o >> 2) % LINE_WORDS);
               report_error();
            end
            assert (mem_wdata_o == expected_mem_word(mem_waddr_o)) else begin
               $display("MISMATCH %s writeback data at %h: expected %h, actual %h",
                        cur_name, mem_waddr_o, expected_mem_word(mem_waddr_o), mem_wdata_o);
               report_error();
            end
            mem_model[mem_waddr_o] = mem_wdata_o;
            mem_wack_i <= 1'b1;
            wr_words++;
            wr_gap = next_random() % 4;
         end else begin
            wr_gap--;
         end
      end
   end

   // Peripheral answers after 1 to 4 cycles
   always @(posedge Clk) begin
      periph_done_i <= 1'b0;
      if (periph_rd_o || periph_wr_o) begin
         per_strobes++;
         per_addr = periph_addr_o;
         if (periph_wr_o) begin
            periph_log[periph_addr_o] = periph_wdata_o;
         end
         per_wait = 1 + next_random() % 4;
      end else if (per_wait > 0) begin
         per_wait--;
         if (per_wait == 0) begin
            periph_rdata_i <= per_addr + 1;
            periph_done_i  <= 1'b1;
         end
      end
   end

   ////////////////////
   // Sequence
   ////////////////////

   initial begin
      rst_n_i     = 1'b0;
      cpu_en_i    = 1'b0;
      cpu_op_i    = OP_READ;
      cpu_addr_i  = '0;
      cpu_wdata_i = '0;
      load_vectors();
      if (vec_name.size() == 0) begin
         $display("No vectors found in %s", VEC_FILE);
         report_error();
      end
      // One extra slot covers reset
      timeout_cycles = (vec_name.size() + 1) * CYCLES_PER_VECTOR;
      repeat (3) @(posedge Clk);
      rst_n_i <= 1'b1;
      @(negedge Clk);
      assert (!cpu_stall_o && !mem_rd_o && !mem_wr_o && !periph_rd_o && !periph_wr_o)
      else begin
         $display("Stall or a bus strobe is high after reset with no request");
         report_error();
      end
      @(posedge Clk);
      for (int i = 0; i < vec_name.size(); i++) begin
         run_vector(i);
      end
      cpu_en_i <= 1'b0;
      @(posedge Clk);
      $display("Done: no errors");
      $finish;
   end

   // Watchdog
   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge Clk);
      $display("Timeout after %0d cycles in %s, the request never completed",
               timeout_cycles, cur_name);
      $display("Done: errors found");
      $fatal(1, "Watchdog expired");
   end

endmodule

// ==== bench/mem_vectors.txt ====
# name op addr wdata rdata mem_reads mem_write_words periph_strobes
# op is R or W, address and data in hex, rdata is ignored on writes
rd_first      R 00000100 00000000 A5A50100 1 0 0
rd_same_line  R 00000108 00000000 A5A50108 0 0 0
wr_hit        W 00000104 DEADBEEF 00000000 0 0 0
rd_after_wr   R 00000104 00000000 DEADBEEF 0 0 0
rd_evict      R 00000180 00000000 A5A50180 1 4 0
rd_refetch    R 00000104 00000000 DEADBEEF 1 0 0
per_rd        R 80000010 00000000 80000011 0 0 1
per_wr        W 80000020 12345678 00000000 0 0 1
per_rd_top    R FFFFFFF0 00000000 FFFFFFF1 0 0 1
wr_miss       W 00000214 0BADF00D 00000000 1 0 0
rd_wr_miss    R 00000214 00000000 0BADF00D 0 0 0
rd_neighbor   R 00000218 00000000 A5A50218 0 0 0
rd_evict2     R 00000A10 00000000 A5A50A10 1 4 0
rd_back2      R 00000214 00000000 0BADF00D 1 0 0
wr_hit2       W 0000021C CAFE0001 00000000 0 0 0
rd_index7     R 00000070 00000000 A5A50070 1 0 0
rd_idx7_last  R 0000007C 00000000 A5A5007C 0 0 0
rd_evict3     R 00001210 00000000 A5A51210 1 4 0
rd_back3      R 0000021C 00000000 CAFE0001 1 0 0
rd_hit3       R 00000214 00000000 0BADF00D 0 0 0
per_wr2       W 90000000 00C0FFEE 00000000 0 0 1
rd_final      R 00000180 00000000 A5A50180 1 0 0
wr_far        W 00004004 11112222 00000000 1 0 0
rd_far        R 00004004 00000000 11112222 0 0 0
rd_flush      R 00000100 00000000 A5A50100 1 4 0
rd_flush_w    R 00000104 00000000 DEADBEEF 0 0 0

// ==== verilog.f ====
hdl/mem_sys_pkg.sv
hdl/mem_controller.sv
hdl/data_cache.sv
hdl/linefill_buffer.sv
hdl/line_write_buffer.sv
hdl/mem_subsystem.sv
bench/tb_mem_subsystem.sv

// ==== Bender.yml ====
package:
  name: mem_subsystem

sources:
  - files:
      - hdl/mem_sys_pkg.sv
      - hdl/mem_controller.sv
      - hdl/data_cache.sv
      - hdl/linefill_buffer.sv
      - hdl/line_write_buffer.sv
      - hdl/mem_subsystem.sv
  - target: test
    files:
      - bench/tb_mem_subsystem.sv
